// File: rtl/ex_pkg.sv
// shared types for the execute stage, imported by every module of the stage
package ex_pkg;

  ////////////////////
  // basic words
  ////////////////////

  // operand and result word
  typedef logic [31:0] data_t;

  // regfile write address
  typedef logic [5:0] waddr_t;

  ////////////////////
  // opcodes
  ////////////////////

  // integer alu operators
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_LTU,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  // low or high product word
  typedef enum logic {
    MUL_L,
    MUL_H
  } mul_op_e;

  // source of the forwarding data word
  typedef enum logic [1:0] {
    RES_NONE,
    RES_ALU,
    RES_MULT,
    RES_CSR
  } res_sel_e;

  ////////////////////
  // request and port bundles
  ////////////////////

  // alu request from decode, 101 bits
  typedef struct packed {
    logic    enable;
    alu_op_e op;
    data_t   operand_a;
    data_t   operand_b;
    // jump target rides on operand c
    data_t   operand_c;
  } alu_req_t;

  // multiplier request from decode, 68 bits
  typedef struct packed {
    logic       enable;
    mul_op_e    op;
    // bit 0 a signed, bit 1 b signed
    logic [1:0] signed_mode;
    data_t      operand_a;
    data_t      operand_b;
  } mul_req_t;

  // regfile write port, forwarding and write-back
  typedef struct packed {
    logic   we;
    waddr_t waddr;
    data_t  wdata;
  } rf_wport_t;

endpackage

// File: rtl/ex_alu.sv
// combinational integer alu used as one copy of the triplicated alu in the execute stage
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::data_t    result_o,
  output logic             cmp_o
);

  import ex_pkg::*;

  data_t       op_a;
  data_t       op_b;
  logic [4:0]  shamt;
  logic        lt_s;
  logic        lt_u;
  logic        eq;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // only the low five bits shift
  assign shamt = op_b[4:0];

  ////////////////////
  // comparator
  ////////////////////

  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  always_comb begin
    case (req_i.op)
      ALU_SLT, ALU_LT:   cmp_o = lt_s;
      ALU_SLTU, ALU_LTU: cmp_o = lt_u;
      ALU_EQ:            cmp_o = eq;
      ALU_NE:            cmp_o = ~eq;
      ALU_GE:            cmp_o = ~lt_s;
      ALU_GEU:           cmp_o = ~lt_u;
      default: begin
        // arithmetic ops never take a branch
        cmp_o = 1'b0;
      end
    endcase
  end

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    case (req_i.op)
      ALU_ADD: result_o = op_a + op_b;
      ALU_SUB: result_o = op_a - op_b;
      ALU_AND: result_o = op_a & op_b;
      ALU_OR:  result_o = op_a | op_b;
      ALU_XOR: result_o = op_a ^ op_b;
      ALU_SLL: result_o = op_a << shamt;
      ALU_SRL: result_o = op_a >> shamt;
      ALU_SRA: result_o = data_t'($signed(op_a) >>> shamt);
      default: begin
        // compares give the flag zero-extended
        result_o = {31'b0, cmp_o};
      end
    endcase
  end

endmodule

// File: rtl/ex_alu_tmr.sv
// triplicated alu with a bitwise two-of-three voter, used in place of a single alu
`timescale 1ns/1ps

module ex_alu_tmr (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::data_t    result_o,
  output logic             cmp_o
);

  import ex_pkg::*;

  // per copy result and compare flag
  data_t       copy_result [3];
  logic        copy_cmp    [3];

  // compare bit on top, result below
  logic [32:0] copy_vec    [3];
  logic [32:0] voted_vec;

  ////////////////////
  // alu copies
  ////////////////////

  // all copies see the same request
  for (genvar i = 0; i < 3; i++) begin : gen_alu
    ex_alu u_alu (
      .req_i    (req_i),
      .result_o (copy_result[i]),
      .cmp_o    (copy_cmp[i])
    );

    assign copy_vec[i] = {copy_cmp[i], copy_result[i]};
  end

  ////////////////////
  // majority voter
  ////////////////////

  // each bit independently, any single bad copy masked
  // two bad copies in the same bit still win
  assign voted_vec = (copy_vec[0] & copy_vec[1])
                   | (copy_vec[0] & copy_vec[2])
                   | (copy_vec[1] & copy_vec[2]);

  assign cmp_o    = voted_vec[32];
  assign result_o = voted_vec[31:0];

endmodule

// File: rtl/ex_mult.sv
// multiplier of the execute stage, single-cycle low product and multi-cycle high product
`timescale 1ns/1ps

module ex_mult #(
  parameter int MULH_CYCLES = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  ex_pkg::mul_req_t req_i,
  input  logic             ex_ready_i,
  output ex_pkg::data_t    result_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  import ex_pkg::*;

  // counter sized for the calc phase
  localparam int CNT_W    = (MULH_CYCLES > 2) ? $clog2(MULH_CYCLES) : 1;
  // calc phase lasts MULH_CYCLES-2 cycles
  localparam int CNT_INIT = (MULH_CYCLES > 2) ? (MULH_CYCLES - 3) : 0;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mulh_state_e;

  mulh_state_e        state_q;
  mulh_state_e        state_d;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   cnt_d;

  logic               mulh_start;
  data_t              mul_lo;
  logic signed [32:0] op_a_q;
  logic signed [32:0] op_b_q;
  logic signed [65:0] mulh_prod;

  ////////////////////
  // low product
  ////////////////////

  // low word same for any signedness
  assign mul_lo = req_i.operand_a * req_i.operand_b;

  ////////////////////
  // high product fsm
  ////////////////////

  assign mulh_start = req_i.enable & (req_i.op == MUL_H) & (state_q == IDLE);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        if (mulh_start) begin
          cnt_d   = CNT_W'(CNT_INIT);
          // two-cycle latency skips calc
          state_d = (MULH_CYCLES > 2) ? CALC : DONE;
        end
      end
      CALC: begin
        if (cnt_q == '0) begin
          state_d = DONE;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      DONE: begin
        // hold result under back-pressure
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // operands sign-extended per mode
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      op_a_q <= {req_i.signed_mode[0] & req_i.operand_a[31], req_i.operand_a};
      op_b_q <= {req_i.signed_mode[1] & req_i.operand_b[31], req_i.operand_b};
    end
  end

  assign mulh_prod = op_a_q * op_b_q;

  ////////////////////
  // outputs
  ////////////////////

  // busy from the first mulh cycle until done
  assign ready_o      = ~(mulh_start | (state_q == CALC));
  assign multicycle_o = ~ready_o;
  assign result_o     = (state_q == DONE) ? mulh_prod[63:32] : mul_lo;

endmodule

// File: rtl/ex_issue_ctrl.sv
// result source decode and ex_ready / ex_valid stall logic of the execute stage
`timescale 1ns/1ps

module ex_issue_ctrl (
  input  logic             alu_en_i,
  input  logic             mult_en_i,
  input  logic             csr_access_i,
  input  logic             lsu_en_i,
  input  logic             mult_ready_i,
  input  logic             lsu_ready_ex_i,
  input  logic             wb_ready_i,
  input  logic             branch_in_ex_i,
  output ex_pkg::res_sel_e res_sel_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  import ex_pkg::*;

  // every unit able to finish this cycle
  logic units_ready;
  logic any_en;

  ////////////////////
  // result source
  ////////////////////

  // csr over mult over alu
  always_comb begin
    if (csr_access_i) begin
      res_sel_o = RES_CSR;
    end else if (mult_en_i) begin
      res_sel_o = RES_MULT;
    end else if (alu_en_i) begin
      res_sel_o = RES_ALU;
    end else begin
      res_sel_o = RES_NONE;
    end
  end

  ////////////////////
  // stall logic
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // branches resolve in ex, no wb needed
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // valid does not look at ex_ready
  assign ex_valid_o = any_en & units_ready;

endmodule

// File: rtl/ex_writeback.sv
// forwarding port mux and ex/wb pipeline register feeding the load write port
`timescale 1ns/1ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::res_sel_e  res_sel_i,
  input  ex_pkg::data_t     alu_result_i,
  input  ex_pkg::data_t     mult_result_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              alu_we_i,
  input  ex_pkg::waddr_t    alu_waddr_i,
  input  logic              rf_we_i,
  input  ex_pkg::waddr_t    rf_waddr_i,
  input  logic              lsu_err_i,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  output ex_pkg::rf_wport_t fw_o,
  output ex_pkg::rf_wport_t wb_o
);

  import ex_pkg::*;

  logic   wb_we_q;
  waddr_t wb_waddr_q;
  logic   load_we;

  ////////////////////
  // forwarding port
  ////////////////////

  always_comb begin
    fw_o.we    = alu_we_i;
    fw_o.waddr = alu_waddr_i;
    case (res_sel_i)
      RES_ALU:  fw_o.wdata = alu_result_i;
      RES_MULT: fw_o.wdata = mult_result_i;
      RES_CSR:  fw_o.wdata = csr_rdata_i;
      default:  fw_o.wdata = '0;
    endcase
  end

  ////////////////////
  // ex/wb register
  ////////////////////

  // faulting loads never write
  assign load_we = rf_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      // wb_ready implied by ex_valid
      wb_we_q <= load_we;
    end else if (wb_ready_i) begin
      // nothing new, flush the slot
      wb_we_q <= 1'b0;
    end
  end

  // address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      wb_waddr_q <= rf_waddr_i;
    end
  end

  // load data arrives straight from the lsu
  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// File: rtl/ex_stage_top.sv
// execute stage top, joins decode, alu, multiplier and result blocks with the branch outputs
`timescale 1ns/1ps

module ex_stage_top #(
  parameter int MULH_CYCLES = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::alu_req_t  alu_req_i,
  input  ex_pkg::mul_req_t  mul_req_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  input  logic              alu_we_i,
  input  logic              rf_we_i,
  input  ex_pkg::waddr_t    alu_waddr_i,
  input  ex_pkg::waddr_t    rf_waddr_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  output ex_pkg::rf_wport_t fw_o,
  output ex_pkg::rf_wport_t wb_o,
  output logic              branch_decision_o,
  output ex_pkg::data_t     jump_target_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  data_t    alu_result;
  logic     alu_cmp;
  data_t    mult_result;
  logic     mult_ready;
  res_sel_e res_sel;

  ////////////////////
  // decode and stall
  ////////////////////

  ex_issue_ctrl u_issue_ctrl (
    .alu_en_i       (alu_req_i.enable),
    .mult_en_i      (mul_req_i.enable),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .res_sel_o      (res_sel),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ////////////////////
  // execute units
  ////////////////////

  ex_alu_tmr u_alu_tmr (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // ex_ready releases a finished mulh
  ex_mult #(
    .MULH_CYCLES (MULH_CYCLES)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mul_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////
  // result ports
  ////////////////////

  ex_writeback u_writeback (
    .clk           (clk),
    .rst_n         (rst_n),
    .res_sel_i     (res_sel),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .alu_we_i      (alu_we_i),
    .alu_waddr_i   (alu_waddr_i),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .lsu_err_i     (lsu_err_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_o          (fw_o),
    .wb_o          (wb_o)
  );

  // branch outcome from the voted compare
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.operand_c;

endmodule

// File: sim/tb_ex_tasks.svh
// testbench helpers for the execute stage, included in the testbench module body
`ifndef TB_EX_TASKS_SVH
`define TB_EX_TASKS_SVH

////////////////////
// stimulus helpers
////////////////////

// next random word from the shared seed
function automatic data_t rand_word();
  rand_word = $random(seed);
endfunction

// quiet bus, all units off
task automatic drive_idle();
  alu_req      <= '0;
  mul_req      <= '0;
  csr_access   <= 1'b0;
  lsu_en       <= 1'b0;
  lsu_ready_ex <= 1'b1;
  lsu_err      <= 1'b0;
  wb_ready     <= 1'b1;
  branch_in_ex <= 1'b0;
  alu_we       <= 1'b0;
  rf_we        <= 1'b0;
  alu_waddr    <= '0;
  rf_waddr     <= '0;
  csr_rdata    <= '0;
  lsu_rdata    <= '0;
endtask

task automatic set_alu(input logic en, input alu_op_e op, input data_t a,
                       input data_t b, input data_t c);
  alu_req.enable    <= en;
  alu_req.op        <= op;
  alu_req.operand_a <= a;
  alu_req.operand_b <= b;
  alu_req.operand_c <= c;
endtask

task automatic set_mul(input logic en, input mul_op_e op, input logic [1:0] mode,
                       input data_t a, input data_t b);
  mul_req.enable      <= en;
  mul_req.op          <= op;
  mul_req.signed_mode <= mode;
  mul_req.operand_a   <= a;
  mul_req.operand_b   <= b;
endtask

////////////////////
// reference models
////////////////////

// rv32 integer ops, compares give the flag as result
task automatic alu_model(input alu_op_e op, input data_t a, input data_t b,
                         output data_t res, output logic cmp);
  logic        lt_u;
  logic        lt_s;
  logic [63:0] ext;
  begin
    lt_u = (a < b);
    // signs differ, sign of a decides
    lt_s = (a[31] != b[31]) ? a[31] : lt_u;
    ext  = {{32{a[31]}}, a} >> b[4:0];
    res  = '0;
    cmp  = 1'b0;
    case (op)
      ALU_ADD:           res = a + b;
      ALU_SUB:           res = a - b;
      ALU_AND:           res = a & b;
      ALU_OR:            res = a | b;
      ALU_XOR:           res = a ^ b;
      ALU_SLL:           res = a << b[4:0];
      ALU_SRL:           res = a >> b[4:0];
      ALU_SRA:           res = ext[31:0];
      ALU_SLT, ALU_LT:   cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_EQ:            cmp = (a == b);
      ALU_NE:            cmp = (a != b);
      ALU_GE:            cmp = ~lt_s;
      ALU_GEU:           cmp = ~lt_u;
    endcase
    // compare group sits after sra in the enum
    if (op >= ALU_SLT) begin
      res = {31'b0, cmp};
    end
  end
endtask

// 64-bit product, extension per operand sign mode
function automatic data_t mul_model(input data_t a, input data_t b,
                                    input logic [1:0] mode, input logic high);
  logic [63:0] wide_a;
  logic [63:0] wide_b;
  logic [63:0] prod;
  begin
    wide_a    = {{32{mode[0] & a[31]}}, a};
    wide_b    = {{32{mode[1] & b[31]}}, b};
    prod      = wide_a * wide_b;
    mul_model = high ? prod[63:32] : prod[31:0];
  end
endfunction

////////////////////
// compare tasks
////////////////////

task automatic check_data(input string name, input data_t got, input data_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("** Error %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_port(input string name, input rf_wport_t got, input rf_wport_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("** Error %s got we %h waddr %h wdata %h expected we %h waddr %h wdata %h",
             name, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("** Error %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

`endif

// File: sim/tb_ex_stage.sv
// testbench top for the execute stage that runs the directed tests and prints the verdict
`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int MULH_CYCLES    = 3;
  // far above the sequence length of under a hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk = 1'b0;
  logic      rst_n;
  alu_req_t  alu_req;
  mul_req_t  mul_req;
  logic      csr_access;
  logic      lsu_en;
  logic      lsu_ready_ex;
  logic      lsu_err;
  logic      wb_ready;
  logic      branch_in_ex;
  logic      alu_we;
  logic      rf_we;
  waddr_t    alu_waddr;
  waddr_t    rf_waddr;
  data_t     csr_rdata;
  data_t     lsu_rdata;
  rf_wport_t fw;
  rf_wport_t wb;
  logic      branch_decision;
  data_t     jump_target;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;

  integer    seed;
  int        n_checks  = 0;
  int        n_errors  = 0;
  int        cycle_cnt = 0;

  `include "tb_ex_tasks.svh"

  // 20 ns period
  always #10 clk = ~clk;

  ex_stage_top #(
    .MULH_CYCLES (MULH_CYCLES)
  ) UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .mul_req_i         (mul_req),
    .csr_access_i      (csr_access),
    .lsu_en_i          (lsu_en),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .branch_in_ex_i    (branch_in_ex),
    .alu_we_i          (alu_we),
    .rf_we_i           (rf_we),
    .alu_waddr_i       (alu_waddr),
    .rf_waddr_i        (rf_waddr),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .fw_o              (fw),
    .wb_o              (wb),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  // hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("run stopped at cycle %0d before the tests were done", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////
  // directed tests
  ////////////////////

  task automatic reset_test();
    @(negedge clk);
    check_bit("wb_o.we", wb.we, 1'b0);
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_bit("mult_multicycle_o", mult_multicycle, 1'b0);
  endtask

  // two passes per op with equal operands on the second
  task automatic alu_test();
    int        i;
    alu_op_e   op;
    data_t     a;
    data_t     b;
    data_t     c;
    data_t     w;
    logic      exp_cmp;
    rf_wport_t exp;
    begin
      for (i = 0; i < 32; i++) begin
        op = alu_op_e'(i[4:1]);
        a  = rand_word();
        b  = i[0] ? a : rand_word();
        c  = rand_word();
        w  = rand_word();
        alu_model(op, a, b, exp.wdata, exp_cmp);
        exp.we    = w[6];
        exp.waddr = w[5:0];
        @(posedge clk);
        set_alu(1'b1, op, a, b, c);
        alu_we    <= w[6];
        alu_waddr <= w[5:0];
        @(negedge clk);
        check_port("fw_o", fw, exp);
        check_bit("branch_decision_o", branch_decision, exp_cmp);
        check_data("jump_target_o", jump_target, c);
      end
      @(posedge clk);
      drive_idle();
    end
  endtask

  // low product, then csr over mult over alu
  task automatic mul_priority_test();
    data_t a;
    data_t b;
    data_t csr;
    begin
      a   = rand_word();
      b   = rand_word();
      csr = rand_word();
      @(posedge clk);
      set_mul(1'b1, MUL_L, 2'b11, a, b);
      set_alu(1'b0, ALU_XOR, a, b, rand_word());
      @(negedge clk);
      check_data("fw_o.wdata", fw.wdata, mul_model(a, b, 2'b11, 1'b0));
      @(posedge clk);
      alu_req.enable <= 1'b1;
      @(negedge clk);
      check_data("fw_o.wdata", fw.wdata, mul_model(a, b, 2'b11, 1'b0));
      @(posedge clk);
      csr_access <= 1'b1;
      csr_rdata  <= csr;
      @(negedge clk);
      check_data("fw_o.wdata", fw.wdata, csr);
      @(posedge clk);
      drive_idle();
      // no source gives zero
      @(negedge clk);
      check_data("fw_o.wdata", fw.wdata, '0);
    end
  endtask

  // high product with optional wb back-pressure at completion
  task automatic mulh_test(input logic [1:0] mode, input logic hold);
    data_t a;
    data_t b;
    data_t exp;
    int    busy;
    begin
      a     = rand_word();
      b     = rand_word();
      // negative operands tell the modes apart
      a[31] = 1'b1;
      b[31] = 1'b1;
      exp   = mul_model(a, b, mode, 1'b1);
      busy  = 0;
      @(posedge clk);
      set_mul(1'b1, MUL_H, mode, a, b);
      wb_ready <= ~hold;
      @(negedge clk);
      while (mult_multicycle) begin
        check_bit("ex_ready_o", ex_ready, 1'b0);
        busy++;
        @(negedge clk);
      end
      if (busy != MULH_CYCLES - 1) begin
        n_errors++;
        $display("mulh in mode %0d was busy for %0d cycles instead of %0d",
                 mode, busy, MULH_CYCLES - 1);
      end
      check_data("fw_o.wdata", fw.wdata, exp);
      check_bit("ex_ready_o", ex_ready, ~hold);
      if (hold) begin
        repeat (2) @(negedge clk);
        check_data("fw_o.wdata", fw.wdata, exp);
        check_bit("mult_multicycle_o", mult_multicycle, 1'b0);
        @(posedge clk);
        wb_ready <= 1'b1;
        @(negedge clk);
        check_bit("ex_ready_o", ex_ready, 1'b1);
        check_data("fw_o.wdata", fw.wdata, exp);
      end
      @(posedge clk);
      set_mul(1'b0, MUL_L, 2'b00, '0, '0);
    end
  endtask

  task automatic writeback_test();
    data_t     w;
    data_t     data;
    rf_wport_t exp;
    begin
      w    = rand_word();
      data = rand_word();
      exp.we    = 1'b1;
      exp.waddr = w[5:0];
      exp.wdata = data;
      // plain load
      @(posedge clk);
      lsu_en    <= 1'b1;
      rf_we     <= 1'b1;
      rf_waddr  <= w[5:0];
      lsu_rdata <= data;
      @(negedge clk);
      check_bit("ex_valid_o", ex_valid, 1'b1);
      @(posedge clk);
      lsu_en   <= 1'b0;
      rf_we    <= 1'b0;
      wb_ready <= 1'b0;
      @(negedge clk);
      check_port("wb_o", wb, exp);
      // port holds while wb stalled
      @(negedge clk);
      check_port("wb_o", wb, exp);
      // faulting load
      @(posedge clk);
      wb_ready <= 1'b1;
      lsu_en   <= 1'b1;
      rf_we    <= 1'b1;
      lsu_err  <= 1'b1;
      rf_waddr <= ~w[5:0];
      @(posedge clk);
      lsu_en   <= 1'b0;
      rf_we    <= 1'b0;
      lsu_err  <= 1'b0;
      @(negedge clk);
      check_bit("wb_o.we", wb.we, 1'b0);
      // good load then idle edge
      @(posedge clk);
      lsu_en   <= 1'b1;
      rf_we    <= 1'b1;
      rf_waddr <= w[5:0];
      @(posedge clk);
      lsu_en <= 1'b0;
      rf_we  <= 1'b0;
      @(negedge clk);
      check_port("wb_o", wb, exp);
      @(negedge clk);
      check_bit("wb_o.we", wb.we, 1'b0);
    end
  endtask

  task automatic stall_test();
    @(posedge clk);
    lsu_ready_ex <= 1'b0;
    set_alu(1'b1, ALU_ADD, rand_word(), rand_word(), rand_word());
    @(negedge clk);
    check_bit("ex_ready_o", ex_ready, 1'b0);
    check_bit("ex_valid_o", ex_valid, 1'b0);
    @(posedge clk);
    branch_in_ex <= 1'b1;
    @(negedge clk);
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_bit("ex_valid_o", ex_valid, 1'b0);
    @(posedge clk);
    drive_idle();
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    seed  = 32'ha8f5_1093;
    rst_n = 1'b0;
    drive_idle();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_test();
    alu_test();
    mul_priority_test();
    // signed, unsigned, signed by unsigned
    mulh_test(2'b11, 1'b0);
    mulh_test(2'b00, 1'b0);
    mulh_test(2'b01, 1'b0);
    mulh_test(2'b01, 1'b1);
    writeback_test();
    stall_test();
    @(negedge clk);
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+sim
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_alu_tmr.sv
rtl/ex_mult.sv
rtl/ex_issue_ctrl.sv
rtl/ex_writeback.sv
rtl/ex_stage_top.sv
sim/tb_ex_stage.sv

// File: Makefile
TOP = tb_ex_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
